// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_apb_subsystem
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
design/apb_bridge_pkg.sv
design/apb_bus_if.sv
design/axi2apb.sv
design/apb_reg_slave.sv
design/apb_return_mux.sv
design/apb_subsystem_top.sv
testbench/apb_subsystem_properties.sv
testbench/tb_apb_subsystem.sv

// File: design/apb_bridge_pkg.sv
`default_nettype none

package apb_bridge_pkg;

    typedef logic [19:0] apb_addr_t;   // byte address, bits 19:15 unused
    typedef logic [31:0] apb_data_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // 4 KB window per peripheral
    localparam int DEV_INDEX_LSB = 12;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_phase_t;

    typedef enum logic [1:0] {
        WRITE_IDLE,
        WRITE_DATA,   // address taken, data pending
        WRITE_WAIT,   // queued or on the APB side
        WRITE_RESP
    } write_state_t;

    typedef enum logic [1:0] {
        READ_IDLE,
        READ_WAIT,    // queued behind a write or a busy bus
        READ_DATA,    // APB transfer running
        READ_RESP
    } read_state_t;

endpackage

`default_nettype wire

// File: design/apb_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface apb_bus_if #(
    parameter int DEV_COUNT = 8
);

    logic [DEV_COUNT-1:0]      psel;     // one-hot
    logic                      penable;
    apb_bridge_pkg::apb_addr_t paddr;
    logic                      pwrite;
    apb_bridge_pkg::apb_data_t pwdata;

    // response of the selected peripheral only
    apb_bridge_pkg::apb_data_t prdata;
    logic                      pready;
    logic                      pslverr;

    modport master (
        output psel, penable, paddr, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    // select bit goes to each peripheral separately
    modport periph (
        input penable, paddr, pwrite, pwdata
    );

    modport drain (
        input  psel,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

// File: design/apb_reg_slave.sv
`timescale 1ns/10ps
`default_nettype none

module apb_reg_slave (
    input  wire                        S_AXI_ACLK,
    input  wire                        S_AXI_ARESETN,
    input  wire                        sel,
    apb_bus_if.periph                  bus,
    output apb_bridge_pkg::apb_data_t  prdata,
    output logic                       pready,
    output logic                       pslverr
);

    apb_bridge_pkg::apb_data_t regs [4];

    logic       wait_q;     // high on the second ACCESS cycle
    logic       unmapped;
    logic [1:0] reg_idx;
    logic       access;

    assign access   = sel && bus.penable;
    assign unmapped = |bus.paddr[11:4];   // only 0x0..0xC exist
    assign reg_idx  = bus.paddr[3:2];

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN)
            wait_q <= 1'b0;
        else if (access)
            wait_q <= !wait_q;
        else
            wait_q <= 1'b0;
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (access && wait_q && bus.pwrite && !unmapped) begin
            regs[reg_idx] <= bus.pwdata;   // ending edge
        end
    end

    assign pready  = wait_q;
    assign pslverr = wait_q && unmapped;
    assign prdata  = unmapped ? '0 : regs[reg_idx];

endmodule

`default_nettype wire

// File: design/apb_return_mux.sv
`timescale 1ns/10ps
`default_nettype none

module apb_return_mux #(
    parameter int DEV_COUNT = 8
) (
    input  wire apb_bridge_pkg::apb_data_t prdata [DEV_COUNT],
    input  wire [DEV_COUNT-1:0]            pready,
    input  wire [DEV_COUNT-1:0]            pslverr,
    apb_bus_if.drain                       apb
);

    // psel is one-hot, so the last match is the only match
    always_comb begin
        apb.prdata = '0;
        for (int i = 0; i < DEV_COUNT; i++) begin
            if (apb.psel[i])
                apb.prdata = prdata[i];
        end
    end

    // nothing selected gives low ready and no error
    assign apb.pready  = |(pready & apb.psel);
    assign apb.pslverr = |(pslverr & apb.psel);

endmodule

`default_nettype wire

// File: design/apb_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module apb_subsystem_top #(
    parameter int DEV_COUNT = 8   // power of two
) (
    input  wire                              S_AXI_ACLK,
    input  wire                              S_AXI_ARESETN,
    input  wire apb_bridge_pkg::apb_addr_t   s_axi_awaddr,
    input  wire                              s_axi_awvalid,
    output wire                              s_axi_awready,
    input  wire apb_bridge_pkg::apb_data_t   s_axi_wdata,
    input  wire                              s_axi_wvalid,
    output wire                              s_axi_wready,
    output wire apb_bridge_pkg::axi_resp_t   s_axi_bresp,
    output wire                              s_axi_bvalid,
    input  wire                              s_axi_bready,
    input  wire apb_bridge_pkg::apb_addr_t   s_axi_araddr,
    input  wire                              s_axi_arvalid,
    output wire                              s_axi_arready,
    output wire apb_bridge_pkg::apb_data_t   s_axi_rdata,
    output wire apb_bridge_pkg::axi_resp_t   s_axi_rresp,
    output wire                              s_axi_rvalid,
    input  wire                              s_axi_rready
);

    apb_bus_if #(.DEV_COUNT(DEV_COUNT)) apb_bus ();

    apb_bridge_pkg::apb_data_t periph_rdata [DEV_COUNT];
    logic [DEV_COUNT-1:0]      periph_ready;
    logic [DEV_COUNT-1:0]      periph_slverr;

    axi2apb #(
        .DEV_COUNT (DEV_COUNT)
    ) u_bridge (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .apb           (apb_bus.master)
    );

    for (genvar i = 0; i < DEV_COUNT; i++) begin : g_periph
        apb_reg_slave u_periph (
            .S_AXI_ACLK    (S_AXI_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .sel           (apb_bus.psel[i]),
            .bus           (apb_bus.periph),
            .prdata        (periph_rdata[i]),
            .pready        (periph_ready[i]),
            .pslverr       (periph_slverr[i])
        );
    end

    apb_return_mux #(
        .DEV_COUNT (DEV_COUNT)
    ) u_return_mux (
        .prdata  (periph_rdata),
        .pready  (periph_ready),
        .pslverr (periph_slverr),
        .apb     (apb_bus.drain)
    );

endmodule

`default_nettype wire

// File: design/axi2apb.sv
`timescale 1ns/10ps
`default_nettype none

module axi2apb #(
    parameter int DEV_COUNT = 8
) (
    input  wire                              S_AXI_ACLK,
    input  wire                              S_AXI_ARESETN,
    input  wire apb_bridge_pkg::apb_addr_t   s_axi_awaddr,
    input  wire                              s_axi_awvalid,
    output logic                             s_axi_awready,
    input  wire apb_bridge_pkg::apb_data_t   s_axi_wdata,
    input  wire                              s_axi_wvalid,
    output logic                             s_axi_wready,
    output apb_bridge_pkg::axi_resp_t        s_axi_bresp,
    output logic                             s_axi_bvalid,
    input  wire                              s_axi_bready,
    input  wire apb_bridge_pkg::apb_addr_t   s_axi_araddr,
    input  wire                              s_axi_arvalid,
    output logic                             s_axi_arready,
    output apb_bridge_pkg::apb_data_t        s_axi_rdata,
    output apb_bridge_pkg::axi_resp_t        s_axi_rresp,
    output logic                             s_axi_rvalid,
    input  wire                              s_axi_rready,
    apb_bus_if.master                        apb
);

    localparam int IDX_W = $clog2(DEV_COUNT);

    apb_bridge_pkg::apb_phase_t   apb_phase;
    apb_bridge_pkg::write_state_t write_state;
    apb_bridge_pkg::read_state_t  read_state;

    apb_bridge_pkg::apb_addr_t awaddr_q;
    apb_bridge_pkg::apb_data_t wdata_q;
    apb_bridge_pkg::apb_addr_t araddr_q;

    logic aw_hs, w_hs, ar_hs;
    logic start_write, start_read;
    logic apb_done, write_done, read_done;

    function automatic logic [DEV_COUNT-1:0] dev_decode(input apb_bridge_pkg::apb_addr_t addr);
        logic [DEV_COUNT-1:0] onehot;
        onehot = '0;
        onehot[addr[apb_bridge_pkg::DEV_INDEX_LSB +: IDX_W]] = 1'b1;
        return onehot;
    endfunction

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign ar_hs = s_axi_arvalid && s_axi_arready;

    // write wins a tie, read also waits out the whole write incl. B
    assign start_write = (apb_phase == apb_bridge_pkg::IDLE) &&
                         (write_state == apb_bridge_pkg::WRITE_WAIT);
    assign start_read  = (apb_phase == apb_bridge_pkg::IDLE) &&
                         (read_state == apb_bridge_pkg::READ_WAIT) &&
                         (write_state == apb_bridge_pkg::WRITE_IDLE);

    assign apb_done   = (apb_phase == apb_bridge_pkg::ACCESS) && apb.pready;
    assign write_done = apb_done && apb.pwrite;
    assign read_done  = apb_done && !apb.pwrite;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            write_state   <= apb_bridge_pkg::WRITE_IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            case (write_state)
                apb_bridge_pkg::WRITE_IDLE: begin
                    s_axi_awready <= 1'b1;
                    if (!s_axi_awready)
                        s_axi_wready <= 1'b1;   // first cycle out of reset
                    if (w_hs)
                        s_axi_wready <= 1'b0;   // data may come ahead of the address
                    if (aw_hs) begin
                        s_axi_awready <= 1'b0;
                        if (w_hs || !s_axi_wready)
                            write_state <= apb_bridge_pkg::WRITE_WAIT;
                        else
                            write_state <= apb_bridge_pkg::WRITE_DATA;
                    end
                end
                apb_bridge_pkg::WRITE_DATA: begin
                    if (w_hs) begin
                        s_axi_wready <= 1'b0;
                        write_state  <= apb_bridge_pkg::WRITE_WAIT;
                    end
                end
                apb_bridge_pkg::WRITE_WAIT: begin
                    if (write_done) begin
                        s_axi_bvalid <= 1'b1;
                        write_state  <= apb_bridge_pkg::WRITE_RESP;
                    end
                end
                apb_bridge_pkg::WRITE_RESP: begin
                    if (s_axi_bready) begin
                        s_axi_bvalid  <= 1'b0;
                        s_axi_awready <= 1'b1;
                        s_axi_wready  <= 1'b1;
                        write_state   <= apb_bridge_pkg::WRITE_IDLE;
                    end
                end
                default: write_state <= apb_bridge_pkg::WRITE_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            read_state    <= apb_bridge_pkg::READ_IDLE;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            case (read_state)
                apb_bridge_pkg::READ_IDLE: begin
                    s_axi_arready <= !ar_hs;
                    if (ar_hs)
                        read_state <= apb_bridge_pkg::READ_WAIT;
                end
                apb_bridge_pkg::READ_WAIT: begin
                    if (start_read)
                        read_state <= apb_bridge_pkg::READ_DATA;
                end
                apb_bridge_pkg::READ_DATA: begin
                    if (read_done) begin
                        s_axi_rvalid <= 1'b1;
                        read_state   <= apb_bridge_pkg::READ_RESP;
                    end
                end
                apb_bridge_pkg::READ_RESP: begin
                    if (s_axi_rready) begin
                        s_axi_rvalid  <= 1'b0;
                        s_axi_arready <= 1'b1;
                        read_state    <= apb_bridge_pkg::READ_IDLE;
                    end
                end
                default: read_state <= apb_bridge_pkg::READ_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            apb_phase   <= apb_bridge_pkg::IDLE;
            apb.psel    <= '0;
            apb.penable <= 1'b0;
            apb.pwrite  <= 1'b0;
        end else begin
            case (apb_phase)
                apb_bridge_pkg::IDLE: begin
                    if (start_write) begin
                        apb_phase  <= apb_bridge_pkg::SETUP;
                        apb.psel   <= dev_decode(awaddr_q);
                        apb.pwrite <= 1'b1;
                    end else if (start_read) begin
                        apb_phase  <= apb_bridge_pkg::SETUP;
                        apb.psel   <= dev_decode(araddr_q);
                        apb.pwrite <= 1'b0;
                    end
                end
                apb_bridge_pkg::SETUP: begin
                    apb_phase   <= apb_bridge_pkg::ACCESS;
                    apb.penable <= 1'b1;
                end
                apb_bridge_pkg::ACCESS: begin
                    if (apb.pready) begin
                        apb_phase   <= apb_bridge_pkg::IDLE;
                        apb.penable <= 1'b0;
                        apb.psel    <= '0;
                    end
                end
                default: apb_phase <= apb_bridge_pkg::IDLE;
            endcase
        end
    end

    // payload, loaded only on handshakes and transfer start/end
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs)
            awaddr_q <= s_axi_awaddr;
        if (w_hs)
            wdata_q <= s_axi_wdata;
        if (ar_hs)
            araddr_q <= s_axi_araddr;
        if (start_write) begin
            apb.paddr  <= awaddr_q;
            apb.pwdata <= wdata_q;   // held through reads too
        end else if (start_read) begin
            apb.paddr <= araddr_q;
        end
        if (write_done)
            s_axi_bresp <= apb.pslverr ? apb_bridge_pkg::RESP_SLVERR : apb_bridge_pkg::RESP_OKAY;
        if (read_done) begin
            s_axi_rdata <= apb.prdata;
            s_axi_rresp <= apb.pslverr ? apb_bridge_pkg::RESP_SLVERR : apb_bridge_pkg::RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: testbench/apb_stimulus.txt
# columns: op addr wdata exp_rdata exp_resp, all but op in hex
# op W is a write, R a read, P a write and a read of the same address in one cycle
W 00000 A0A00000 00000000 0
W 00004 A0A00004 00000000 0
W 00008 A0A00008 00000000 0
W 0000C A0A0000C 00000000 0
R 00000 00000000 A0A00000 0
R 00004 00000000 A0A00004 0
R 00008 00000000 A0A00008 0
R 0000C 00000000 A0A0000C 0
W 01000 B1B10000 00000000 0
P 02004 B2B20004 B2B20004 0
W 03008 B3B30008 00000000 0
P 0400C B4B4000C B4B4000C 0
W 05000 B5B50000 00000000 0
P 06004 B6B60004 B6B60004 0
W 07008 B7B70008 00000000 0
R 01000 00000000 B1B10000 0
R 8B008 00000000 B3B30008 0
R F8000 00000000 A0A00000 0
R 7F008 00000000 B7B70008 0
R 05000 00000000 B5B50000 0
W 00010 DEADBEEF 00000000 2
R 00010 00000000 00000000 2
R 04FFC 00000000 00000000 2
R 00000 00000000 A0A00000 0
R 0400C 00000000 B4B4000C 0

// File: testbench/apb_subsystem_properties.sv
`timescale 1ns/10ps
`default_nettype none

module apb_subsystem_properties #(
    parameter int DEV_COUNT = 8
) (
    input wire                            S_AXI_ACLK,
    input wire                            S_AXI_ARESETN,
    input wire [DEV_COUNT-1:0]            psel,
    input wire                            penable,
    input wire apb_bridge_pkg::apb_addr_t paddr,
    input wire                            pwrite,
    input wire apb_bridge_pkg::apb_data_t pwdata,
    input wire                            pready,
    input wire                            bvalid,
    input wire                            bready,
    input wire apb_bridge_pkg::axi_resp_t bresp,
    input wire                            rvalid,
    input wire                            rready,
    input wire apb_bridge_pkg::apb_data_t rdata,
    input wire apb_bridge_pkg::axi_resp_t rresp
);

    a_psel_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $onehot0(psel))
        else $error("more than one psel bit set");

    a_enable_sel: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        penable |-> |psel)
        else $error("penable high with no peripheral selected");

    // from SETUP up to the ending ACCESS edge
    a_req_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (|psel && !(penable && pready)) |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else $error("APB request changed during a transfer");

    a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (bvalid && !bready) |=> bvalid && $stable(bresp))
        else $error("B response dropped or changed before acceptance");

    a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (rvalid && !rready) |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("R response dropped or changed before acceptance");

endmodule

bind axi2apb apb_subsystem_properties #(
    .DEV_COUNT (DEV_COUNT)
) u_properties (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .psel          (apb.psel),
    .penable       (apb.penable),
    .paddr         (apb.paddr),
    .pwrite        (apb.pwrite),
    .pwdata        (apb.pwdata),
    .pready        (apb.pready),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .bresp         (s_axi_bresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp)
);

`default_nettype wire

// File: testbench/tb_apb_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_apb_subsystem;

    localparam int    DEV_COUNT = 8;
    localparam string STIM_FILE = "testbench/apb_stimulus.txt";

    logic                      S_AXI_ACLK;
    logic                      S_AXI_ARESETN;
    apb_bridge_pkg::apb_addr_t s_axi_awaddr;
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    apb_bridge_pkg::apb_data_t s_axi_wdata;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    apb_bridge_pkg::axi_resp_t s_axi_bresp;
    logic                      s_axi_bvalid;
    logic                      s_axi_bready;
    apb_bridge_pkg::apb_addr_t s_axi_araddr;
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    apb_bridge_pkg::apb_data_t s_axi_rdata;
    apb_bridge_pkg::axi_resp_t s_axi_rresp;
    logic                      s_axi_rvalid;
    logic                      s_axi_rready;

    // one entry per stimulus line
    byte                       op_q    [$];
    apb_bridge_pkg::apb_addr_t addr_q  [$];
    apb_bridge_pkg::apb_data_t wdata_q [$];
    apb_bridge_pkg::apb_data_t rdata_q [$];
    apb_bridge_pkg::axi_resp_t resp_q  [$];

    apb_bridge_pkg::apb_data_t shadow [8][4];   // [peripheral][word]

    int     value_errors = 0;
    int     other_errors = 0;
    integer seed = 16430;
    bit     loaded = 1'b0;

    apb_subsystem_top #(.DEV_COUNT(DEV_COUNT)) dut (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            value_errors++;
        end
    endtask

    task automatic load_stimulus();
        int                        fd;
        int                        n;
        string                     line;
        byte                       op;
        apb_bridge_pkg::apb_addr_t addr;
        apb_bridge_pkg::apb_data_t wdata;
        apb_bridge_pkg::apb_data_t rdata;
        apb_bridge_pkg::axi_resp_t resp;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#" &&
                $sscanf(line, "%c %h %h %h %h", op, addr, wdata, rdata, resp) == 5) begin
                op_q.push_back(op);
                addr_q.push_back(addr);
                wdata_q.push_back(wdata);
                rdata_q.push_back(rdata);
                resp_q.push_back(resp);
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge and returns once every raised valid was taken
    task automatic issue(input bit do_write, input bit do_read,
                         input apb_bridge_pkg::apb_addr_t addr,
                         input apb_bridge_pkg::apb_data_t data);
        bit aw_go;
        bit w_go;
        bit ar_go;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_araddr  = addr;
        s_axi_awvalid = do_write;
        s_axi_wvalid  = do_write;
        s_axi_arvalid = do_read;
        while (s_axi_awvalid || s_axi_wvalid || s_axi_arvalid) begin
            aw_go = s_axi_awvalid && s_axi_awready;   // ready is stable until next rise
            w_go  = s_axi_wvalid && s_axi_wready;
            ar_go = s_axi_arvalid && s_axi_arready;
            @(negedge S_AXI_ACLK);
            if (aw_go)
                s_axi_awvalid = 1'b0;
            if (w_go)
                s_axi_wvalid = 1'b0;
            if (ar_go)
                s_axi_arvalid = 1'b0;
        end
    endtask

    task automatic take_bresp(input apb_bridge_pkg::axi_resp_t exp);
        int                        delay;
        apb_bridge_pkg::axi_resp_t held;
        while (!s_axi_bvalid)
            @(negedge S_AXI_ACLK);
        held  = s_axi_bresp;
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) begin
            @(negedge S_AXI_ACLK);
            check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd1);
            check_value("s_axi_bresp", 32'(s_axi_bresp), 32'(held));
            check_value("s_axi_awready", 32'(s_axi_awready), 32'd0);
            check_value("s_axi_wready", 32'(s_axi_wready), 32'd0);
        end
        s_axi_bready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_bready = 1'b0;
        check_value("s_axi_bresp", 32'(held), 32'(exp));
    endtask

    task automatic take_rresp(input apb_bridge_pkg::apb_data_t exp_data,
                              input apb_bridge_pkg::axi_resp_t exp_resp);
        int                        delay;
        apb_bridge_pkg::apb_data_t held_data;
        apb_bridge_pkg::axi_resp_t held_resp;
        while (!s_axi_rvalid)
            @(negedge S_AXI_ACLK);
        held_data = s_axi_rdata;
        held_resp = s_axi_rresp;
        delay     = $unsigned($random(seed)) % 6;
        repeat (delay) begin
            @(negedge S_AXI_ACLK);
            check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd1);
            check_value("s_axi_rdata", s_axi_rdata, held_data);
            check_value("s_axi_rresp", 32'(s_axi_rresp), 32'(held_resp));
            check_value("s_axi_arready", 32'(s_axi_arready), 32'd0);
        end
        s_axi_rready = 1'b1;
        @(negedge S_AXI_ACLK);
        s_axi_rready = 1'b0;
        check_value("s_axi_rdata", held_data, exp_data);
        check_value("s_axi_rresp", 32'(held_resp), 32'(exp_resp));
    endtask

    initial begin
        apb_bridge_pkg::apb_addr_t addr;
        apb_bridge_pkg::apb_data_t model_rdata;
        apb_bridge_pkg::axi_resp_t model_resp;
        logic [2:0]                dev;
        logic [1:0]                word;
        logic                      unmapped;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        for (int d = 0; d < 8; d++)
            for (int w = 0; w < 4; w++)
                shadow[d][w] = '0;
        load_stimulus();
        loaded = 1'b1;

        repeat (5) @(negedge S_AXI_ACLK);
        check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd0);
        check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd0);
        check_value("s_axi_awready", 32'(s_axi_awready), 32'd0);
        check_value("s_axi_wready", 32'(s_axi_wready), 32'd0);
        check_value("s_axi_arready", 32'(s_axi_arready), 32'd0);
        S_AXI_ARESETN = 1'b1;
        @(negedge S_AXI_ACLK);
        check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd0);
        check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd0);
        check_value("s_axi_awready", 32'(s_axi_awready), 32'd1);
        check_value("s_axi_wready", 32'(s_axi_wready), 32'd1);
        check_value("s_axi_arready", 32'(s_axi_arready), 32'd1);

        for (int i = 0; i < op_q.size(); i++) begin
            addr       = addr_q[i];
            dev        = addr[14:12];   // bits 19:15 alias
            word       = addr[3:2];
            unmapped   = |addr[11:4];
            model_resp = unmapped ? apb_bridge_pkg::RESP_SLVERR : apb_bridge_pkg::RESP_OKAY;
            if (op_q[i] != "R" && !unmapped)
                shadow[dev][word] = wdata_q[i];
            model_rdata = unmapped ? '0 : shadow[dev][word];
            if (resp_q[i] !== model_resp || (op_q[i] != "W" && rdata_q[i] !== model_rdata)) begin
                $display("stimulus entry %0d disagrees with the register model", i + 1);
                other_errors++;
            end
            case (op_q[i])
                "W": begin
                    issue(1'b1, 1'b0, addr, wdata_q[i]);
                    take_bresp(resp_q[i]);
                end
                "R": begin
                    issue(1'b0, 1'b1, addr, '0);
                    take_rresp(rdata_q[i], resp_q[i]);
                end
                "P": begin
                    issue(1'b1, 1'b1, addr, wdata_q[i]);
                    take_bresp(resp_q[i]);   // read is held behind the write
                    take_rresp(rdata_q[i], resp_q[i]);
                end
                default: begin
                    $display("unknown operation on stimulus entry %0d", i + 1);
                    other_errors++;
                end
            endcase
        end

        repeat (2) @(negedge S_AXI_ACLK);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run length scales with the number of stimulus entries
    initial begin
        int limit;
        wait (loaded);
        limit = op_q.size() * 40 + 200;
        repeat (limit) @(posedge S_AXI_ACLK);
        $display("watchdog expired after %0d cycles, a transfer never completed", limit);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
